// File: tests/wb_cases.txt
// ctrl(valid rf_we csr_re csr_we ertn) cause(adef sys brk ine ale) pc waddr wdata csr_num
// wmask wvalue esubcode | exp_we exp_wdata exp_flush exp_flush_pc readback_reg readback_value
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11100 0 1c000000 1 0 0 0 0 0 f 8 0 0 1 8
11100 0 1c000004 2 0 c 0 0 0 f 1c000000 0 0 2 1c000000
11000 0 1c000008 3 12345678 0 0 0 0 f 12345678 0 0 3 12345678
11000 0 1c00000c 0 deadbeef 0 0 0 0 f deadbeef 0 0 0 0
10010 0 1c000010 0 0 31 ffffffff a5a5a5a5 0 0 0 0 0 3 12345678
11110 0 1c000014 4 0 31 0000ff00 12345678 0 f a5a5a5a5 0 0 4 a5a5a5a5
11100 0 1c000018 5 0 31 0 0 0 f a5a556a5 0 0 5 a5a556a5
11000 0 1c00001c 6 66666666 0 0 0 0 f 66666666 0 0 6 66666666
11000 0 1c000020 9 90909090 0 0 0 0 f 90909090 0 0 9 90909090
11000 01000 1c000100 6 11111111 0 0 0 a5 0 0 1 1c000000 6 66666666
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11100 0 1c000000 7 0 6 0 0 0 f 1c000100 0 0 7 1c000100
11100 0 1c000004 8 0 5 0 0 0 f 294b0000 0 0 8 294b0000
11000 00111 1c000200 a 0 0 0 0 3 0 0 1 1c000000 9 90909090
11000 0 1c000204 9 99999999 0 0 0 0 0 0 0 0 9 90909090
11100 0 1c000008 a 0 5 0 0 0 f 00cc0000 0 0 a 00cc0000
11000 11001 1c000300 b 0 0 0 0 1ff 0 0 1 1c000000 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11100 0 1c00000c b 0 5 0 0 0 f 7fc80000 0 0 b 7fc80000
10010 0 1c000010 0 0 6 ffffffff 1c000400 0 0 0 0 0 0 0
10010 0 1c000014 0 0 1 ffffffff 00000005 0 0 0 0 0 0 0
11100 0 1c000018 c 0 1 0 0 0 f 5 0 0 c 5
10001 0 1c00001c 0 0 0 0 0 0 0 0 1 1c000400 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11100 0 1c000400 d 0 0 0 0 0 f d 0 0 d d
11100 0 1c000404 e 0 6 0 0 0 f 1c000400 0 0 e 1c000400
10010 0 1c000408 0 0 c ffffffff 1c00803f 0 0 0 0 0 0 0
10000 00100 1c00040c 0 0 0 0 0 0 0 0 1 1c008000 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11100 0 1c008000 f 0 6 0 0 0 f 1c00040c 0 0 f 1c00040c

// File: build.f
src/la_pkg.sv
src/wb_stage.sv
src/csr_file.sv
src/reg_file.sv
src/wb_subsystem.sv
tests/tb_wb_subsystem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_wb_subsystem -f build.f -o sim_wb
./obj_dir/sim_wb

// File: tests/tb_wb_subsystem.sv
`timescale 1ns/1ps

module tb_wb_subsystem
    import la_pkg::*;
();

    localparam int NCOL      = 15;   // words per case line
    localparam int MAX_CASES = 64;
    localparam int NONE      = -2;   // nothing driven in this slot
    localparam int BUBBLE    = -1;   // random bubble with valid low
    localparam logic [31:0] SEED = 32'h7ec1ab8d;

    // columns of a case line
    localparam int C_CTRL      = 0;
    localparam int C_CAUSE     = 1;
    localparam int C_PC        = 2;
    localparam int C_WADDR     = 3;
    localparam int C_WDATA     = 4;
    localparam int C_CSR_NUM   = 5;
    localparam int C_WMASK     = 6;
    localparam int C_WVALUE    = 7;
    localparam int C_ESUB      = 8;
    localparam int C_EXP_WE    = 9;
    localparam int C_EXP_WDATA = 10;
    localparam int C_EXP_FLUSH = 11;
    localparam int C_EXP_FPC   = 12;
    localparam int C_RB_IDX    = 13;
    localparam int C_RB_VALUE  = 14;

    logic       clk;
    logic       resetn;
    logic       mem_valid;
    word_t      mem_pc;
    logic       mem_rf_we;
    reg_addr_t  mem_rf_waddr;
    word_t      mem_rf_wdata;
    logic       mem_csr_re;
    logic       mem_csr_we;
    csr_num_t   mem_csr_num;
    word_t      mem_csr_wmask;
    word_t      mem_csr_wvalue;
    logic       mem_ertn;
    logic       mem_excep_adef;
    logic       mem_excep_sys;
    logic       mem_excep_brk;
    logic       mem_excep_ine;
    logic       mem_excep_ale;
    esubcode_t  mem_esubcode;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;
    logic       flush;
    word_t      flush_pc;
    reg_addr_t  rf_raddr;
    word_t      rf_rdata;

    logic [31:0] cases_mem [NCOL*MAX_CASES];
    int n_cases;
    int cycle_count = 0;
    int cycle_limit = 0;  // zero until the cases are counted
    int seed_ret;
    int line_idx;
    int prev1;  // item now in wb
    int prev2;  // item whose write landed at the last edge
    int next_item;

    wb_subsystem UUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("*** FAILED ***");
            $fatal(1, "timeout: the run did not finish within %0d cycles", cycle_limit);
        end
    end

    // bubbles and empty slots read as all zero
    function automatic logic [31:0] case_field(input int idx, input int col);
        if (idx < 0) begin
            return 32'h0;
        end
        return cases_mem[idx * NCOL + col];
    endfunction

    function automatic string item_name(input int idx);
        if (idx < 0) begin
            return "bubble";
        end
        return $sformatf("case %0d", idx + 1);
    endfunction

    task automatic check_value(input logic [31:0] observed, input logic [31:0] expected,
                               input string what);
        if (observed !== expected) begin
            $display("Fail at time %0t: %s, observed %h, expected %h",
                     $time, what, observed, expected);
            $display("*** FAILED ***");
            $fatal(1, "wrong value on %s", what);
        end
    endtask

    task automatic drive_item(input int idx);
        logic [31:0] ctrl;
        logic [31:0] cause;
        ctrl           = case_field(idx, C_CTRL);   // one hex digit per flag
        cause          = case_field(idx, C_CAUSE);
        mem_valid      = ctrl[16];
        mem_rf_we      = ctrl[12];
        mem_csr_re     = ctrl[8];
        mem_csr_we     = ctrl[4];
        mem_ertn       = ctrl[0];
        mem_excep_adef = cause[16];
        mem_excep_sys  = cause[12];
        mem_excep_brk  = cause[8];
        mem_excep_ine  = cause[4];
        mem_excep_ale  = cause[0];
        mem_pc         = case_field(idx, C_PC);
        mem_rf_waddr   = reg_addr_t'(case_field(idx, C_WADDR));
        mem_rf_wdata   = case_field(idx, C_WDATA);
        mem_csr_num    = csr_num_t'(case_field(idx, C_CSR_NUM));
        mem_csr_wmask  = case_field(idx, C_WMASK);
        mem_csr_wvalue = case_field(idx, C_WVALUE);
        mem_esubcode   = esubcode_t'(case_field(idx, C_ESUB));
    endtask

    task automatic check_outputs(input int idx);
        logic [31:0] exp_we;
        logic [31:0] exp_flush;
        string       name;
        exp_we    = case_field(idx, C_EXP_WE);
        exp_flush = case_field(idx, C_EXP_FLUSH);
        name      = item_name(idx);
        check_value(32'(debug_wb_rf_we), exp_we, {name, " debug_wb_rf_we"});
        if (exp_we != 0) begin
            check_value(debug_wb_pc, case_field(idx, C_PC), {name, " debug_wb_pc"});
            check_value(32'(debug_wb_rf_wnum), case_field(idx, C_WADDR),
                        {name, " debug_wb_rf_wnum"});
            check_value(debug_wb_rf_wdata, case_field(idx, C_EXP_WDATA),
                        {name, " debug_wb_rf_wdata"});
        end
        check_value(32'(flush), exp_flush, {name, " flush"});
        if (exp_flush != 0) begin
            check_value(flush_pc, case_field(idx, C_EXP_FPC), {name, " flush_pc"});
        end
    endtask

    task automatic check_readback(input int idx);
        check_value(rf_rdata, case_field(idx, C_RB_VALUE),
                    $sformatf("%s read back of r%0d", item_name(idx),
                              case_field(idx, C_RB_IDX)));
    endtask

    initial begin
        clk      = 1'b0;
        resetn   = 1'b0;
        rf_raddr = '0;
        drive_item(NONE);
        seed_ret = $urandom(SEED);
        for (int i = 0; i < NCOL * MAX_CASES; i++) begin
            cases_mem[i] = 32'hffff_ffff;  // marks the end of the file
        end
        $readmemh("tests/wb_cases.txt", cases_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && cases_mem[n_cases * NCOL] !== 32'hffff_ffff) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("*** FAILED ***");
            $fatal(1, "no stimulus lines could be read from tests/wb_cases.txt");
        end
        cycle_limit = 4 * n_cases + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        line_idx = 0;
        prev1    = NONE;
        prev2    = NONE;
        while (line_idx < n_cases || prev1 != NONE || prev2 != NONE) begin
            if (prev1 != NONE) begin
                check_outputs(prev1);
            end
            if (prev2 != NONE) begin
                check_readback(prev2);
            end
            // the slot after a flush comes from the file so the squash gets tested
            if (line_idx >= n_cases) begin
                next_item = NONE;
            end else if (prev1 >= 0 && case_field(prev1, C_EXP_FLUSH) == 0 &&
                         ($urandom % 4) == 0) begin
                next_item = BUBBLE;
            end else begin
                next_item = line_idx;
                line_idx++;
            end
            drive_item(next_item);
            rf_raddr = reg_addr_t'(case_field(prev1, C_RB_IDX));  // sampled next slot
            prev2    = prev1;
            prev1    = next_item;
            @(negedge clk);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: src/wb_subsystem.sv
`timescale 1ns/1ps

module wb_subsystem
    import la_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       mem_valid,
    input  word_t      mem_pc,
    input  logic       mem_rf_we,
    input  reg_addr_t  mem_rf_waddr,
    input  word_t      mem_rf_wdata,
    input  logic       mem_csr_re,
    input  logic       mem_csr_we,
    input  csr_num_t   mem_csr_num,
    input  word_t      mem_csr_wmask,
    input  word_t      mem_csr_wvalue,
    input  logic       mem_ertn,
    input  logic       mem_excep_adef,
    input  logic       mem_excep_sys,
    input  logic       mem_excep_brk,
    input  logic       mem_excep_ine,
    input  logic       mem_excep_ale,
    input  esubcode_t  mem_esubcode,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata,
    output logic       flush,
    output word_t      flush_pc,
    input  reg_addr_t  rf_raddr,  // stands in for the decode read port
    output word_t      rf_rdata
);

    // wb to csr file
    logic      csr_re;
    csr_num_t  csr_num;
    logic      csr_we;
    word_t     csr_wmask;
    word_t     csr_wvalue;
    logic      wb_ex;
    ecode_t    wb_ecode;
    esubcode_t wb_esubcode;
    word_t     wb_ex_pc;
    logic      ertn_flush;
    // csr file back to wb
    word_t     csr_rvalue;
    word_t     era;
    word_t     eentry;
    // wb to register file
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_wdata      (mem_rf_wdata),
        .mem_csr_re        (mem_csr_re),
        .mem_csr_we        (mem_csr_we),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_wmask     (mem_csr_wmask),
        .mem_csr_wvalue    (mem_csr_wvalue),
        .mem_ertn          (mem_ertn),
        .mem_excep_adef    (mem_excep_adef),
        .mem_excep_sys     (mem_excep_sys),
        .mem_excep_brk     (mem_excep_brk),
        .mem_excep_ine     (mem_excep_ine),
        .mem_excep_ale     (mem_excep_ale),
        .mem_esubcode      (mem_esubcode),
        .csr_rvalue        (csr_rvalue),
        .era               (era),
        .eentry            (eentry),
        .csr_re            (csr_re),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .wb_ex             (wb_ex),
        .wb_ecode          (wb_ecode),
        .wb_esubcode       (wb_esubcode),
        .wb_ex_pc          (wb_ex_pc),
        .ertn_flush        (ertn_flush),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .flush             (flush),
        .flush_pc          (flush_pc)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .resetn      (resetn),
        .csr_re      (csr_re),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_ex_pc    (wb_ex_pc),
        .ertn_flush  (ertn_flush),
        .csr_rvalue  (csr_rvalue),
        .era         (era),
        .eentry      (eentry)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import la_pkg::*;
(
    input  logic      clk,
    // write port from wb
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    // read port
    input  reg_addr_t rf_raddr,
    output word_t     rf_rdata
);

    word_t regs [32];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (rf_we && (rf_waddr != '0)) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // combinational read with r0 forced to zero
    assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

// File: src/csr_file.sv
`timescale 1ns/1ps

module csr_file
    import la_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      csr_re,
    input  csr_num_t  csr_num,
    input  logic      csr_we,
    input  word_t     csr_wmask,
    input  word_t     csr_wvalue,
    input  logic      wb_ex,
    input  ecode_t    wb_ecode,
    input  esubcode_t wb_esubcode,
    input  word_t     wb_ex_pc,
    input  logic      ertn_flush,
    output word_t     csr_rvalue,
    output word_t     era,
    output word_t     eentry
);

    // crmd with da held at 1 since paging is out of scope
    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    // prmd
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    // estat exception fields only
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era_q;
    logic [25:0] eentry_va;  // entry is 64-byte aligned
    word_t       save_q [4];

    word_t       rd_raw;     // addressed register, ungated
    word_t       wr_merged;  // old value with masked bits replaced

    always_comb begin
        rd_raw = '0;
        case (csr_num)
            CSR_CRMD:   rd_raw = {28'b0, 1'b1, crmd_ie, crmd_plv};
            CSR_PRMD:   rd_raw = {29'b0, prmd_pie, prmd_pplv};
            CSR_ESTAT:  rd_raw = {1'b0, estat_esubcode, estat_ecode, 16'b0};
            CSR_ERA:    rd_raw = era_q;
            CSR_EENTRY: rd_raw = {eentry_va, 6'b0};
            CSR_SAVE0:  rd_raw = save_q[0];
            CSR_SAVE1:  rd_raw = save_q[1];
            CSR_SAVE2:  rd_raw = save_q[2];
            CSR_SAVE3:  rd_raw = save_q[3];
            default:    rd_raw = '0;  // unimplemented csr
        endcase
    end

    assign csr_rvalue = csr_re ? rd_raw : '0;
    assign wr_merged  = (rd_raw & ~csr_wmask) | (csr_wvalue & csr_wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv       <= 2'b0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_q          <= '0;
            eentry_va      <= EENTRY_RESET[31:6];
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wb_ex) begin
            // trap entry saves the mode and drops to kernel with interrupts off
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'b0;
            crmd_ie        <= 1'b0;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_q          <= wb_ex_pc;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;  // restore previous mode
            crmd_ie  <= prmd_pie;
        end else if (csr_we) begin
            case (csr_num)
                CSR_CRMD: begin
                    crmd_plv <= wr_merged[1:0];
                    crmd_ie  <= wr_merged[2];
                end
                CSR_PRMD: begin
                    prmd_pplv <= wr_merged[1:0];
                    prmd_pie  <= wr_merged[2];
                end
                CSR_ERA:    era_q     <= wr_merged;
                CSR_EENTRY: eentry_va <= wr_merged[31:6];
                CSR_SAVE0:  save_q[0] <= wr_merged;
                CSR_SAVE1:  save_q[1] <= wr_merged;
                CSR_SAVE2:  save_q[2] <= wr_merged;
                CSR_SAVE3:  save_q[3] <= wr_merged;
                default: ;  // estat and unknown numbers ignore writes
            endcase
        end
    end

    assign era    = era_q;
    assign eentry = {eentry_va, 6'b0};

endmodule

// File: src/wb_stage.sv
`timescale 1ns/1ps

module wb_stage
    import la_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    // retiring item from the memory stage
    input  logic      mem_valid,
    input  word_t     mem_pc,
    input  logic      mem_rf_we,
    input  reg_addr_t mem_rf_waddr,
    input  word_t     mem_rf_wdata,
    input  logic      mem_csr_re,
    input  logic      mem_csr_we,
    input  csr_num_t  mem_csr_num,
    input  word_t     mem_csr_wmask,
    input  word_t     mem_csr_wvalue,
    input  logic      mem_ertn,
    input  logic      mem_excep_adef,
    input  logic      mem_excep_sys,
    input  logic      mem_excep_brk,
    input  logic      mem_excep_ine,
    input  logic      mem_excep_ale,
    input  esubcode_t mem_esubcode,
    // csr file side
    input  word_t     csr_rvalue,
    input  word_t     era,
    input  word_t     eentry,
    output logic      csr_re,
    output csr_num_t  csr_num,
    output logic      csr_we,
    output word_t     csr_wmask,
    output word_t     csr_wvalue,
    output logic      wb_ex,
    output ecode_t    wb_ecode,
    output esubcode_t wb_esubcode,
    output word_t     wb_ex_pc,
    output logic      ertn_flush,
    // register file write port
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    // trace
    output word_t     debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata,
    // pipeline redirect
    output logic      flush,
    output word_t     flush_pc
);

    logic      wb_valid;
    word_t     wb_pc;
    logic      wb_rf_we;
    reg_addr_t wb_rf_waddr;
    word_t     wb_rf_wdata;
    logic      wb_csr_re;
    logic      wb_csr_we;
    csr_num_t  wb_csr_num;
    word_t     wb_csr_wmask;
    word_t     wb_csr_wvalue;
    logic      wb_ertn;
    logic      wb_adef, wb_sys, wb_brk, wb_ine, wb_ale;
    esubcode_t wb_subcode;

    logic      excep_any;  // any cause bit set
    logic      commit_ok;  // valid, no trap, no return

    // an item arriving during a flush cycle is squashed
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_pc         <= mem_pc;
            wb_rf_we      <= mem_rf_we;
            wb_rf_waddr   <= mem_rf_waddr;
            wb_rf_wdata   <= mem_rf_wdata;
            wb_csr_re     <= mem_csr_re;
            wb_csr_we     <= mem_csr_we;
            wb_csr_num    <= mem_csr_num;
            wb_csr_wmask  <= mem_csr_wmask;
            wb_csr_wvalue <= mem_csr_wvalue;
            wb_ertn       <= mem_ertn;
            wb_adef       <= mem_excep_adef;
            wb_sys        <= mem_excep_sys;
            wb_brk        <= mem_excep_brk;
            wb_ine        <= mem_excep_ine;
            wb_ale        <= mem_excep_ale;
            wb_subcode    <= mem_esubcode;
        end
    end

    assign excep_any = wb_adef | wb_sys | wb_brk | wb_ine | wb_ale;
    assign commit_ok = wb_valid & ~excep_any & ~wb_ertn;

    // trap takes precedence over a return in the same item
    assign wb_ex      = wb_valid & excep_any;
    assign ertn_flush = wb_valid & wb_ertn & ~excep_any;

    // fixed cause priority
    assign wb_ecode = wb_adef ? ECODE_ADEF :
                      wb_sys  ? ECODE_SYS  :
                      wb_brk  ? ECODE_BRK  :
                      wb_ine  ? ECODE_INE  :
                                ECODE_ALE;
    assign wb_esubcode = wb_subcode;
    assign wb_ex_pc    = wb_pc;

    assign csr_re     = wb_valid & wb_csr_re;
    assign csr_num    = wb_csr_num;
    assign csr_we     = commit_ok & wb_csr_we;
    assign csr_wmask  = wb_csr_wmask;
    assign csr_wvalue = wb_csr_wvalue;

    // csr reads return the old value into the destination register
    assign rf_we    = commit_ok & wb_rf_we;
    assign rf_waddr = wb_rf_waddr;
    assign rf_wdata = wb_csr_re ? csr_rvalue : wb_rf_wdata;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

    assign flush    = wb_ex | ertn_flush;
    assign flush_pc = wb_ex ? eentry : era;

endmodule

// File: src/la_pkg.sv
package la_pkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;      // data word or pc
    typedef logic [4:0]  reg_addr_t;  // general register index
    typedef logic [13:0] csr_num_t;   // csr number
    typedef logic [5:0]  ecode_t;     // exception code
    typedef logic [8:0]  esubcode_t;  // exception subcode

    // exception codes as written into estat
    localparam ecode_t ECODE_ADEF = 6'h08;  // fetch address error
    localparam ecode_t ECODE_ALE  = 6'h09;  // misaligned access
    localparam ecode_t ECODE_SYS  = 6'h0b;  // syscall
    localparam ecode_t ECODE_BRK  = 6'h0c;  // break
    localparam ecode_t ECODE_INE  = 6'h0d;  // undefined instruction

    // csr numbers held in this scope
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;

    // trap entry address after reset
    localparam word_t EENTRY_RESET = 32'h1c00_0000;

endpackage
